/* fir_filter.f */
+incdir+hdl
hdl/fir_pkg.sv
hdl/tap_cfg_if.sv
hdl/fir_apb_regs.sv
hdl/fir_serial_core.sv
hdl/fir_filter.sv
verif/fir_filter_tb.sv

/* hdl/fir_apb_regs.sv */
// APB register block, no wait states (pready is tied high)
// Tap count writes outside 1..FIR_MAX_TAPS are refused with pslverr
// Unmapped offsets read zero and respond with pslverr
`timescale 1ns/1ps
`default_nettype none

`include "fir_cfg.svh"

module fir_apb_regs (
    input  wire                    clock,
    input  wire                    arst_n,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire [`FIR_APB_AW-1:0]  paddr,
    input  wire [31:0]             pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    tap_cfg_if.ctrl                cfg
);

    fir_pkg::n_taps_t   n_taps;
    fir_pkg::tap_t      tap_data;
    fir_pkg::tap_addr_t tap_addr;
    logic               tap_write;

    logic access;
    logic sel_ctrl;
    logic sel_data;
    logic sel_addr;
    logic ctrl_ok;

    assign access   = psel && penable;
    assign sel_ctrl = (paddr == fir_pkg::REG_CTRL);
    assign sel_data = (paddr == fir_pkg::REG_TAP_DATA);
    assign sel_addr = (paddr == fir_pkg::REG_TAP_ADDR);

    // The whole 32-bit word is checked, not just the stored low bits
    assign ctrl_ok = (pwdata != 32'd0) && (pwdata <= 32'(`FIR_MAX_TAPS));

    assign pready  = 1'b1;
    assign pslverr = access && (!(sel_ctrl || sel_data || sel_addr) ||
                                (pwrite && sel_ctrl && !ctrl_ok));

    always_comb begin
        prdata = '0;
        if (sel_ctrl) begin
            prdata[$bits(n_taps)-1:0] = n_taps;
        end else if (sel_data) begin
            prdata[`FIR_TAP_W-1:0] = tap_data;
        end else if (sel_addr) begin
            prdata[$bits(tap_addr)-1:0] = tap_addr;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            n_taps    <= fir_pkg::n_taps_t'(`FIR_MAX_TAPS);
            tap_data  <= '0;
            tap_addr  <= '0;
            tap_write <= 1'b0;
        end else begin
            tap_write <= 1'b0;
            if (access && pwrite) begin
                if (sel_ctrl && ctrl_ok) begin
                    n_taps <= pwdata[$bits(n_taps)-1:0];
                end
                if (sel_data) begin
                    tap_data <= pwdata[`FIR_TAP_W-1:0];
                end
                // Address write is the commit trigger for the staged tap
                if (sel_addr) begin
                    tap_addr  <= pwdata[$bits(tap_addr)-1:0];
                    tap_write <= 1'b1;
                end
            end
        end
    end

    assign cfg.n_taps    = n_taps;
    assign cfg.tap_data  = tap_data;
    assign cfg.tap_addr  = tap_addr;
    assign cfg.tap_write = tap_write;

endmodule

`default_nettype wire

/* hdl/fir_cfg.svh */
// Build-time sizes for the FIR subsystem
// FIR_ACC_W must cover FIR_DATA_W + FIR_TAP_W + clog2(FIR_MAX_TAPS)
// so the full-precision sum cannot overflow
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

// Sample and coefficient widths
`define FIR_DATA_W   16
`define FIR_TAP_W    16

// Tap memory depth, also the reset value of the tap count
`define FIR_MAX_TAPS 8

`define FIR_ACC_W    35
`define FIR_APB_AW   8

`endif

/* hdl/fir_filter.sv */
// FIR filter top level, APB configuration plus sample and result streams
// Stream timing is that of the serial core, the register block sits off
// the data path
`timescale 1ns/1ps
`default_nettype none

`include "fir_cfg.svh"

module fir_filter (
    input  wire                   clock,
    input  wire                   arst_n,
    // APB configuration port
    input  wire                   psel,
    input  wire                   penable,
    input  wire                   pwrite,
    input  wire [`FIR_APB_AW-1:0] paddr,
    input  wire [31:0]            pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Sample input stream
    input  wire                   s_valid,
    output logic                  s_ready,
    input  wire fir_pkg::sample_t s_data,
    // Result output stream
    output logic                  m_valid,
    input  wire                   m_ready,
    output fir_pkg::acc_t         m_data
);

    tap_cfg_if cfg_bus ();

    fir_apb_regs u_regs (
        .clock   (clock),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg_bus.ctrl)
    );

    fir_serial_core u_core (
        .clock   (clock),
        .arst_n  (arst_n),
        .s_valid (s_valid),
        .s_data  (s_data),
        .s_ready (s_ready),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_data  (m_data),
        .cfg     (cfg_bus.core)
    );

endmodule

`default_nettype wire

/* hdl/fir_pkg.sv */
// Shared FIR data types and APB register offsets
// All sample, tap and result types are two's complement signed
`default_nettype none

`include "fir_cfg.svh"

package fir_pkg;

    typedef logic signed [`FIR_DATA_W-1:0] sample_t;
    typedef logic signed [`FIR_TAP_W-1:0]  tap_t;
    typedef logic signed [`FIR_ACC_W-1:0]  acc_t;

    // Index into the tap memory and delay line
    typedef logic [$clog2(`FIR_MAX_TAPS)-1:0] tap_addr_t;

    // Must hold the value FIR_MAX_TAPS itself, hence the extra code point
    typedef logic [$clog2(`FIR_MAX_TAPS+1)-1:0] n_taps_t;

    // Byte offsets of the 32-bit registers
    localparam logic [`FIR_APB_AW-1:0] REG_CTRL     = 'h00;
    localparam logic [`FIR_APB_AW-1:0] REG_TAP_DATA = 'h04;
    // A write to this offset commits REG_TAP_DATA into the tap memory
    localparam logic [`FIR_APB_AW-1:0] REG_TAP_ADDR = 'h08;

endpackage

`default_nettype wire

/* hdl/fir_serial_core.sv */
// Serial FIR core, one multiply per cycle, one sample in flight
// Latency from input accept to m_valid is n_taps+1 cycles
// Tap writes during a computation may corrupt that result
`timescale 1ns/1ps
`default_nettype none

`include "fir_cfg.svh"

module fir_serial_core (
    input  wire                clock,
    input  wire                arst_n,
    input  wire                s_valid,
    input  wire fir_pkg::sample_t s_data,
    output logic               s_ready,
    output logic               m_valid,
    input  wire                m_ready,
    output fir_pkg::acc_t      m_data,
    tap_cfg_if.core            cfg
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MAC,
        ST_FLUSH,
        ST_HOLD
    } state_t;

    state_t state;

    fir_pkg::tap_t    tap_mem    [`FIR_MAX_TAPS];
    fir_pkg::sample_t delay_line [`FIR_MAX_TAPS];

    // Tap count sampled at accept so a reprogram never splits a sample
    fir_pkg::n_taps_t   n_lat;
    fir_pkg::tap_addr_t k;

    logic signed [`FIR_DATA_W+`FIR_TAP_W-1:0] prod;
    fir_pkg::acc_t                            acc;

    logic accept;

    assign s_ready = (state == ST_IDLE);
    assign m_valid = (state == ST_HOLD);
    assign accept  = s_valid && s_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `FIR_MAX_TAPS; i++) begin
                tap_mem[i] <= '0;
            end
        end else if (cfg.tap_write) begin
            tap_mem[cfg.tap_addr] <= cfg.tap_data;
        end
    end

    // Entry k holds x[n-k] once the current sample has shifted in
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `FIR_MAX_TAPS; i++) begin
                delay_line[i] <= '0;
            end
        end else if (accept) begin
            delay_line[0] <= s_data;
            for (int i = 1; i < `FIR_MAX_TAPS; i++) begin
                delay_line[i] <= delay_line[i-1];
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            n_lat <= fir_pkg::n_taps_t'(`FIR_MAX_TAPS);
            k     <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (s_valid) begin
                        n_lat <= cfg.n_taps;
                        k     <= '0;
                        state <= ST_MAC;
                    end
                end
                ST_MAC: begin
                    k <= k + 1'b1;
                    if (fir_pkg::n_taps_t'(k) == n_lat - 1'b1) begin
                        state <= ST_FLUSH;
                    end
                end
                ST_FLUSH: state <= ST_HOLD;
                ST_HOLD: begin
                    if (m_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Product is registered, so the accumulator trails the tap counter by one
    // cycle and the last product is folded in during ST_FLUSH
    always_ff @(posedge clock) begin
        case (state)
            ST_IDLE: begin
                prod <= '0;
                acc  <= '0;
            end
            ST_MAC: begin
                prod <= tap_mem[k] * delay_line[k];
                acc  <= acc + fir_pkg::acc_t'(prod);
            end
            ST_FLUSH: m_data <= acc + fir_pkg::acc_t'(prod);
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/tap_cfg_if.sv */
// Configuration path from the register block to the filter core
// tap_write is a single-cycle strobe, tap_addr and tap_data are valid with it
`timescale 1ns/1ps
`default_nettype none

interface tap_cfg_if;

    fir_pkg::n_taps_t   n_taps;
    fir_pkg::tap_addr_t tap_addr;
    fir_pkg::tap_t      tap_data;
    logic               tap_write;

    modport ctrl (output n_taps, output tap_addr, output tap_data, output tap_write);

    modport core (input n_taps, input tap_addr, input tap_data, input tap_write);

endinterface

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the FIR filter testbench with Verilator and run it
# The exit status is non-zero if the build fails or the testbench stops on an error

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module fir_filter_tb \
    -f fir_filter.f \
    -Mdir obj_dir \
    -o fir_filter_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/fir_filter_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

/* verif/fir_filter_tb.sv */
// Self-checking testbench for the FIR filter top level
// Inputs change on the falling clock edge, outputs are sampled 1 ns after it
// Taps and tap count are reprogrammed only while the core is idle
`timescale 1ns/1ps
`default_nettype none

`include "fir_cfg.svh"

module fir_filter_tb;

    localparam int SEED      = 32'h069d_7faa;
    localparam int N_IMPULSE = `FIR_MAX_TAPS;
    localparam int N_RANDOM  = 200;
    localparam int N_SHORT   = 20;
    localparam int N_LATENCY = 3;
    localparam int N_SAMPLES = N_IMPULSE + N_RANDOM + 2 * N_SHORT + N_LATENCY;
    // Back-pressure can stretch every sample, hence the factor of 4
    localparam longint WATCHDOG_NS =
        longint'(N_SAMPLES * (`FIR_MAX_TAPS + 4) + 2000) * 10 * 4;

    logic clock;
    logic arst_n;
    logic psel;
    logic penable;
    logic pwrite;
    logic [`FIR_APB_AW-1:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic s_valid;
    logic s_ready;
    fir_pkg::sample_t s_data;
    logic m_valid;
    logic m_ready;
    fir_pkg::acc_t m_data;

    integer seed;
    integer bp_seed;
    bit bp_on;
    int n_in;
    int n_out;
    int n_taps_cur;
    fir_pkg::tap_t    taps [`FIR_MAX_TAPS];
    fir_pkg::sample_t hist [`FIR_MAX_TAPS];
    fir_pkg::acc_t    exp_q [$];

    fir_filter uut (
        .clock   (clock),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_data  (s_data),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_data  (m_data)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic abort_run(input string why);
        $display("=== FAIL ===");
        $fatal(1, "%s", why);
    endtask

    task automatic check_result(input fir_pkg::acc_t got, input fir_pkg::acc_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: result %0d, expected %0d", $time, got, exp);
            abort_run("filter result mismatch");
        end
    endtask

    task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s read 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
            abort_run("register read data mismatch");
        end
    endtask

    task automatic check_slverr(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s pslverr %b, expected %b", $time, what, got, exp);
            abort_run("APB error response mismatch");
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run("handshake level mismatch");
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t ns: latency %0d cycles, expected %0d", $time, got, exp);
            abort_run("output latency mismatch");
        end
    endtask

    // y[n] = sum of h[k] * x[n-k] for k below n, with x[0] the newest sample
    function automatic fir_pkg::acc_t ref_fir(input fir_pkg::tap_t h [`FIR_MAX_TAPS],
                                              input fir_pkg::sample_t x [`FIR_MAX_TAPS],
                                              input int n);
        fir_pkg::acc_t sum;
        sum = '0;
        for (int k = 0; k < n; k++) begin
            sum = sum + fir_pkg::acc_t'(h[k]) * fir_pkg::acc_t'(x[k]);
        end
        return sum;
    endfunction

    // Called on a falling edge, returns on the falling edge after the access phase
    task automatic apb_xfer(input logic wr, input logic [`FIR_APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clock);
        penable = 1'b1;
        #1;
        rdata  = prdata;
        slverr = pslverr;
        check_level(pready, 1'b1, "pready in access phase");
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
    endtask

    task automatic apb_write(input logic [`FIR_APB_AW-1:0] addr, input logic [31:0] wdata,
                             input logic exp_err);
        logic [31:0] rd;
        logic err;
        apb_xfer(1'b1, addr, wdata, rd, err);
        check_slverr(err, exp_err, $sformatf("write to 0x%02h", addr));
    endtask

    task automatic apb_read(input logic [`FIR_APB_AW-1:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        logic [31:0] rd;
        logic err;
        apb_xfer(1'b0, addr, 32'd0, rd, err);
        check_slverr(err, exp_err, $sformatf("read of 0x%02h", addr));
        check_rdata(rd, exp_data, $sformatf("offset 0x%02h", addr));
    endtask

    task automatic load_tap(input int idx, input fir_pkg::tap_t val);
        apb_write(fir_pkg::REG_TAP_DATA, {16'h0000, val}, 1'b0);
        apb_write(fir_pkg::REG_TAP_ADDR, 32'(idx), 1'b0);
        taps[idx] = val;
    endtask

    task automatic set_count(input int n, input logic exp_err);
        apb_write(fir_pkg::REG_CTRL, 32'(n), exp_err);
        if (!exp_err) begin
            n_taps_cur = n;
        end
    endtask

    // The accept happens on the rising edge after this call
    task automatic record_sample(input fir_pkg::sample_t x);
        for (int i = `FIR_MAX_TAPS - 1; i > 0; i--) begin
            hist[i] = hist[i-1];
        end
        hist[0] = x;
        exp_q.push_back(ref_fir(taps, hist, n_taps_cur));
        n_in++;
    endtask

    task automatic send_sample(input fir_pkg::sample_t x);
        s_valid = 1'b1;
        s_data  = x;
        while (!s_ready) begin
            @(negedge clock);
        end
        record_sample(x);
        @(negedge clock);
        s_valid = 1'b0;
        s_data  = '0;
    endtask

    task automatic send_burst(input int count);
        for (int i = 0; i < count; i++) begin
            repeat ($random(seed) & 1) @(negedge clock);
            send_sample(fir_pkg::sample_t'($random(seed)));
        end
    endtask

    task automatic drain;
        while (n_out != n_in) begin
            @(negedge clock);
        end
    endtask

    task automatic measure_latency(input int n);
        int cycles;
        set_count(n, 1'b0);
        check_level(s_ready, 1'b1, "s_ready while idle");
        s_valid = 1'b1;
        s_data  = fir_pkg::sample_t'($random(seed));
        record_sample(s_data);
        @(negedge clock);
        s_valid = 1'b0;
        cycles  = 0;
        while (!m_valid) begin
            check_level(s_ready, 1'b0, "s_ready during computation");
            @(negedge clock);
            cycles++;
        end
        check_latency(cycles, n + 1);
        check_level(s_ready, 1'b0, "s_ready while result held");
        @(negedge clock);
        check_level(s_ready, 1'b1, "s_ready after output transfer");
    endtask

    // Random back-pressure on the result stream
    initial begin
        forever begin
            @(negedge clock);
            m_ready = bp_on ? (($random(bp_seed) & 3) != 0) : 1'b1;
        end
    end

    initial begin
        forever begin
            @(negedge clock);
            #1;
            if (m_valid && m_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Output transfer at %0t ns with no sample outstanding", $time);
                    abort_run("unexpected extra result");
                end else begin
                    check_result(m_data, exp_q.pop_front());
                    n_out++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired with %0d of %0d results seen", n_out, n_in);
        abort_run("simulation timed out");
    end

    initial begin
        seed       = SEED;
        bp_seed    = SEED;
        bp_on      = 1'b0;
        n_in       = 0;
        n_out      = 0;
        n_taps_cur = `FIR_MAX_TAPS;
        arst_n     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        s_valid    = 1'b0;
        s_data     = '0;
        m_ready    = 1'b0;
        for (int i = 0; i < `FIR_MAX_TAPS; i++) begin
            taps[i] = '0;
            hist[i] = '0;
        end
        repeat (8) @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);

        // Reset values, then readback of written fields
        apb_read(fir_pkg::REG_CTRL, 32'(`FIR_MAX_TAPS), 1'b0);
        apb_read(fir_pkg::REG_TAP_DATA, 32'd0, 1'b0);
        apb_read(fir_pkg::REG_TAP_ADDR, 32'd0, 1'b0);
        load_tap(5, 16'sha5c3);
        apb_read(fir_pkg::REG_TAP_DATA, 32'h0000_a5c3, 1'b0);
        apb_read(fir_pkg::REG_TAP_ADDR, 32'd5, 1'b0);
        set_count(5, 1'b0);
        apb_read(fir_pkg::REG_CTRL, 32'd5, 1'b0);

        // Refused tap counts keep the old value, unmapped offsets read zero
        set_count(0, 1'b1);
        apb_read(fir_pkg::REG_CTRL, 32'd5, 1'b0);
        set_count(`FIR_MAX_TAPS + 1, 1'b1);
        apb_read(fir_pkg::REG_CTRL, 32'd5, 1'b0);
        apb_read(8'h0c, 32'd0, 1'b1);
        apb_write(8'h40, 32'hffff_ffff, 1'b1);
        set_count(`FIR_MAX_TAPS, 1'b0);

        // Impulse into an all-zero delay line returns the taps in order
        for (int k = 0; k < `FIR_MAX_TAPS; k++) begin
            load_tap(k, fir_pkg::tap_t'(1000 * k - 2500 + 3 * k * k));
        end
        for (int i = 0; i < N_IMPULSE; i++) begin
            send_sample((i == 0) ? 16'sd1 : 16'sd0);
        end
        drain;

        for (int k = 0; k < `FIR_MAX_TAPS; k++) begin
            load_tap(k, fir_pkg::tap_t'($random(seed)));
        end
        bp_on = 1'b1;
        send_burst(N_RANDOM);
        drain;

        // Older samples stay in the delay line across the count changes
        set_count(3, 1'b0);
        send_burst(N_SHORT);
        drain;
        set_count(1, 1'b0);
        send_burst(N_SHORT);
        drain;

        bp_on = 1'b0;
        @(negedge clock);
        measure_latency(1);
        measure_latency(3);
        measure_latency(`FIR_MAX_TAPS);
        drain;

        // With every result taken the core must be idle with nothing left to present
        check_level(m_valid, 1'b0, "m_valid after the last result");
        check_level(s_ready, 1'b1, "s_ready after the last result");
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
